// File: common/axi_lite_defs.svh
`ifndef AXI_LITE_DEFS_SVH
`define AXI_LITE_DEFS_SVH

// ----------------------------------------------------------
// Bus widths.
// ----------------------------------------------------------

// Byte address width.
`define AXI_ADDR_WIDTH 64
// Data word width.
`define AXI_DATA_WIDTH 32

// Memory depth, log2 of the word count.
`define MEM_WORDS_LOG2 8

// AXI response codes.
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_DECERR 2'b11

`endif

// File: common/axi_lite_pkg.sv
`default_nettype none

`include "axi_lite_defs.svh"

package axi_lite_pkg;

    // Byte address.
    typedef logic [`AXI_ADDR_WIDTH - 1:0] t_addr;

    // One data word.
    typedef logic [`AXI_DATA_WIDTH - 1:0] t_data;

    // AXI response, high bit set on any error.
    typedef logic [1:0] t_resp;

    // One strobe bit per data byte.
    typedef logic [`AXI_DATA_WIDTH / 8 - 1:0] t_strb;

endpackage

`default_nettype wire

// File: axi_master/axi4_lite_master_read.sv
`timescale 1ns/1ps
`default_nettype none

module axi4_lite_master_read (
    input  logic                clk,
    input  logic                arstn,

    // Client side.
    input  axi_lite_pkg::t_addr i_addr,
    input  logic                i_start_read,
    output axi_lite_pkg::t_data o_data,
    output logic                o_access_fault,
    output logic                o_done,

    // AR channel.
    input  logic                AR_READY,
    output logic                AR_VALID,
    output axi_lite_pkg::t_addr AR_ADDR,

    // R channel.
    input  axi_lite_pkg::t_data R_DATA,
    input  axi_lite_pkg::t_resp R_RESP,
    input  logic                R_VALID,
    output logic                R_READY
);

    // ----------------------------------------------------------
    // State machine.
    // ----------------------------------------------------------

    typedef enum logic [1:0] {
        IDLE    = 2'b00,
        AR_READ = 2'b01,
        READ    = 2'b10,
        RESP    = 2'b11
    } t_state;

    t_state state;

    logic ar_hs;
    logic r_hs;

    assign ar_hs = AR_VALID & AR_READY;
    assign r_hs  = R_VALID & R_READY;

    // Control flow and handshake outputs.
    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            state          <= IDLE;
            AR_VALID       <= 1'b0;
            R_READY        <= 1'b0;
            o_access_fault <= 1'b0;
        end else begin
            case (state)
                IDLE: if (i_start_read) begin
                    AR_VALID <= 1'b1;
                    state    <= AR_READ;
                end
                // Hold the address until the slave takes it.
                AR_READ: if (ar_hs) begin
                    AR_VALID <= 1'b0;
                    R_READY  <= 1'b1;
                    state    <= READ;
                end
                READ: if (r_hs) begin
                    R_READY        <= 1'b0;
                    // SLVERR and DECERR both have the high bit.
                    o_access_fault <= R_RESP[1];
                    state          <= RESP;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Address and read data.
    always_ff @(posedge clk) begin
        if (state == IDLE && i_start_read) begin
            AR_ADDR <= i_addr;
        end
        if (state == READ && r_hs) begin
            o_data <= R_DATA;
        end
    end

    // One-cycle done in RESP.
    assign o_done = (state == RESP);

endmodule

`default_nettype wire

// File: axi_master/axi4_lite_master_write.sv
`timescale 1ns/1ps
`default_nettype none

module axi4_lite_master_write (
    input  logic                clk,
    input  logic                arstn,

    // Client side.
    input  axi_lite_pkg::t_addr i_addr,
    input  axi_lite_pkg::t_data i_data,
    input  axi_lite_pkg::t_strb i_strb,
    input  logic                i_start_write,
    output logic                o_access_fault,
    output logic                o_done,

    // AW channel.
    input  logic                AW_READY,
    output logic                AW_VALID,
    output axi_lite_pkg::t_addr AW_ADDR,

    // W channel.
    input  logic                W_READY,
    output logic                W_VALID,
    output axi_lite_pkg::t_data W_DATA,
    output axi_lite_pkg::t_strb W_STRB,

    // B channel.
    input  logic                B_VALID,
    input  axi_lite_pkg::t_resp B_RESP,
    output logic                B_READY
);

    // ----------------------------------------------------------
    // State machine.
    // ----------------------------------------------------------

    typedef enum logic [1:0] {
        IDLE      = 2'b00,
        ADDR_DATA = 2'b01,
        WAIT_RESP = 2'b10,
        RESP      = 2'b11
    } t_state;

    t_state state;

    // Phase completion flags.
    logic aw_done;
    logic w_done;

    logic aw_hs;
    logic w_hs;
    logic b_hs;

    assign aw_hs = AW_VALID & AW_READY;
    assign w_hs  = W_VALID & W_READY;
    assign b_hs  = B_VALID & B_READY;

    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            state          <= IDLE;
            AW_VALID       <= 1'b0;
            W_VALID        <= 1'b0;
            B_READY        <= 1'b0;
            aw_done        <= 1'b0;
            w_done         <= 1'b0;
            o_access_fault <= 1'b0;
        end else begin
            case (state)
                // Address and data go out together.
                IDLE: if (i_start_write) begin
                    AW_VALID <= 1'b1;
                    W_VALID  <= 1'b1;
                    aw_done  <= 1'b0;
                    w_done   <= 1'b0;
                    state    <= ADDR_DATA;
                end
                ADDR_DATA: begin
                    // Each valid drops on its own handshake.
                    if (aw_hs) begin
                        AW_VALID <= 1'b0;
                        aw_done  <= 1'b1;
                    end
                    if (w_hs) begin
                        W_VALID <= 1'b0;
                        w_done  <= 1'b1;
                    end
                    // Both phases done, in either order.
                    if ((aw_done | aw_hs) & (w_done | w_hs)) begin
                        B_READY <= 1'b1;
                        state   <= WAIT_RESP;
                    end
                end
                WAIT_RESP: if (b_hs) begin
                    B_READY        <= 1'b0;
                    o_access_fault <= B_RESP[1];
                    state          <= RESP;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Write payload, captured at the start.
    always_ff @(posedge clk) begin
        if (state == IDLE && i_start_write) begin
            AW_ADDR <= i_addr;
            W_DATA  <= i_data;
            W_STRB  <= i_strb;
        end
    end

    assign o_done = (state == RESP);

endmodule

`default_nettype wire

// File: logic/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic                clk,
    input  logic                arstn,

    // Instruction fetch client.
    input  logic                i_if_req,
    input  axi_lite_pkg::t_addr i_if_addr,
    output axi_lite_pkg::t_data o_if_data,
    output logic                o_if_fault,
    output logic                o_if_done,

    // Data load client.
    input  logic                i_ld_req,
    input  axi_lite_pkg::t_addr i_ld_addr,
    output axi_lite_pkg::t_data o_ld_data,
    output logic                o_ld_fault,
    output logic                o_ld_done,

    // Read master side.
    output logic                o_start_read,
    output axi_lite_pkg::t_addr o_addr,
    input  axi_lite_pkg::t_data i_rd_data,
    input  logic                i_rd_fault,
    input  logic                i_rd_done
);

    typedef enum logic {
        IDLE = 1'b0,
        BUSY = 1'b1
    } t_state;

    t_state state;

    // Pending requests and their addresses.
    logic                pend_if;
    logic                pend_ld;
    axi_lite_pkg::t_addr if_addr_q;
    axi_lite_pkg::t_addr ld_addr_q;

    // Owner of the current or last transaction, set means data port.
    logic                last_ld;
    logic                pick_ld;

    // Held results per client.
    axi_lite_pkg::t_data if_data_q;
    axi_lite_pkg::t_data ld_data_q;
    logic                if_fault_q;
    logic                ld_fault_q;

    // ----------------------------------------------------------
    // Grant.
    // ----------------------------------------------------------

    // Data port wins only alone or when fetch went last.
    assign pick_ld      = pend_ld & (~pend_if | ~last_ld);
    assign o_start_read = (state == IDLE) & (pend_if | pend_ld);
    assign o_addr       = pick_ld ? ld_addr_q : if_addr_q;

    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            state      <= IDLE;
            pend_if    <= 1'b0;
            pend_ld    <= 1'b0;
            // Fetch port goes first after reset.
            last_ld    <= 1'b1;
            if_fault_q <= 1'b0;
            ld_fault_q <= 1'b0;
        end else begin
            if (i_if_req) pend_if <= 1'b1;
            if (i_ld_req) pend_ld <= 1'b1;
            case (state)
                IDLE: if (o_start_read) begin
                    last_ld <= pick_ld;
                    state   <= BUSY;
                end
                BUSY: if (i_rd_done) begin
                    state <= IDLE;
                    if (last_ld) begin
                        pend_ld    <= 1'b0;
                        ld_fault_q <= i_rd_fault;
                    end else begin
                        pend_if    <= 1'b0;
                        if_fault_q <= i_rd_fault;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Addresses on the strobe, results on done.
    always_ff @(posedge clk) begin
        if (i_if_req) if_addr_q <= i_if_addr;
        if (i_ld_req) ld_addr_q <= i_ld_addr;
        if (o_if_done) if_data_q <= i_rd_data;
        if (o_ld_done) ld_data_q <= i_rd_data;
    end

    // ----------------------------------------------------------
    // Client results.
    // ----------------------------------------------------------

    assign o_if_done = (state == BUSY) & i_rd_done & ~last_ld;
    assign o_ld_done = (state == BUSY) & i_rd_done & last_ld;

    // Pass through on done, held copy afterwards.
    assign o_if_data  = o_if_done ? i_rd_data : if_data_q;
    assign o_if_fault = o_if_done ? i_rd_fault : if_fault_q;
    assign o_ld_data  = o_ld_done ? i_rd_data : ld_data_q;
    assign o_ld_fault = o_ld_done ? i_rd_fault : ld_fault_q;

endmodule

`default_nettype wire

// File: logic/axi4_lite_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_lite_defs.svh"

module axi4_lite_memory (
    input  logic                clk,
    input  logic                arstn,

    // Read channel.
    input  logic                AR_VALID,
    input  axi_lite_pkg::t_addr AR_ADDR,
    output logic                AR_READY,
    output axi_lite_pkg::t_data R_DATA,
    output axi_lite_pkg::t_resp R_RESP,
    output logic                R_VALID,
    input  logic                R_READY,

    // Write channel.
    input  logic                AW_VALID,
    input  axi_lite_pkg::t_addr AW_ADDR,
    output logic                AW_READY,
    input  logic                W_VALID,
    input  axi_lite_pkg::t_data W_DATA,
    input  axi_lite_pkg::t_strb W_STRB,
    output logic                W_READY,
    output logic                B_VALID,
    output axi_lite_pkg::t_resp B_RESP,
    input  logic                B_READY
);

    localparam int IDX_W  = `MEM_WORDS_LOG2;
    localparam int WORDS  = 1 << IDX_W;
    localparam int STRB_W = $bits(axi_lite_pkg::t_strb);

    axi_lite_pkg::t_data mem [WORDS];

    // Word index is the byte address over four.
    logic [IDX_W - 1:0] rd_idx;
    logic [IDX_W - 1:0] wr_idx;
    logic               rd_hit;
    logic               wr_hit;
    logic               ar_hs;
    logic               wr_hs;

    assign rd_idx = AR_ADDR[IDX_W + 1:2];
    assign wr_idx = AW_ADDR[IDX_W + 1:2];
    // Any bit above the array means decode error.
    assign rd_hit = (AR_ADDR >> (IDX_W + 2)) == '0;
    assign wr_hit = (AW_ADDR >> (IDX_W + 2)) == '0;

    assign ar_hs = AR_VALID & AR_READY;
    assign wr_hs = AW_VALID & AW_READY & W_VALID & W_READY;

    // ----------------------------------------------------------
    // Read channel.
    // ----------------------------------------------------------

    typedef enum logic [1:0] {
        RD_IDLE = 2'b00,
        RD_ADDR = 2'b01,
        RD_DATA = 2'b10
    } t_rd_state;

    t_rd_state rd_state;

    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            rd_state <= RD_IDLE;
            AR_READY <= 1'b0;
            R_VALID  <= 1'b0;
            R_RESP   <= `AXI_RESP_OKAY;
        end else begin
            case (rd_state)
                // Ready one cycle after valid shows up.
                RD_IDLE: if (AR_VALID) begin
                    AR_READY <= 1'b1;
                    rd_state <= RD_ADDR;
                end
                RD_ADDR: if (ar_hs) begin
                    AR_READY <= 1'b0;
                    R_VALID  <= 1'b1;
                    R_RESP   <= rd_hit ? `AXI_RESP_OKAY : `AXI_RESP_DECERR;
                    rd_state <= RD_DATA;
                end
                // Hold data until the master takes it.
                RD_DATA: if (R_READY) begin
                    R_VALID  <= 1'b0;
                    rd_state <= RD_IDLE;
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    // Out of range reads return zero.
    always_ff @(posedge clk) begin
        if (rd_state == RD_ADDR && ar_hs) begin
            R_DATA <= rd_hit ? mem[rd_idx] : '0;
        end
    end

    // ----------------------------------------------------------
    // Write channel.
    // ----------------------------------------------------------

    typedef enum logic [1:0] {
        WR_IDLE   = 2'b00,
        WR_ACCEPT = 2'b01,
        WR_RESP   = 2'b10
    } t_wr_state;

    t_wr_state wr_state;

    always_ff @(posedge clk, negedge arstn) begin
        if (!arstn) begin
            wr_state <= WR_IDLE;
            AW_READY <= 1'b0;
            W_READY  <= 1'b0;
            B_VALID  <= 1'b0;
            B_RESP   <= `AXI_RESP_OKAY;
        end else begin
            case (wr_state)
                // Wait for address and data both.
                WR_IDLE: if (AW_VALID && W_VALID) begin
                    AW_READY <= 1'b1;
                    W_READY  <= 1'b1;
                    wr_state <= WR_ACCEPT;
                end
                WR_ACCEPT: if (wr_hs) begin
                    AW_READY <= 1'b0;
                    W_READY  <= 1'b0;
                    B_VALID  <= 1'b1;
                    B_RESP   <= wr_hit ? `AXI_RESP_OKAY : `AXI_RESP_DECERR;
                    wr_state <= WR_RESP;
                end
                WR_RESP: if (B_READY) begin
                    B_VALID  <= 1'b0;
                    wr_state <= WR_IDLE;
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // Byte-lane write, only inside the array.
    always_ff @(posedge clk) begin
        if (wr_state == WR_ACCEPT && wr_hs && wr_hit) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (W_STRB[b]) begin
                    mem[wr_idx][8 * b +: 8] <= W_DATA[8 * b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/mem_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top (
    input  logic                clk,
    input  logic                arstn,

    // Instruction fetch port.
    input  logic                i_if_req,
    input  axi_lite_pkg::t_addr i_if_addr,
    output axi_lite_pkg::t_data o_if_data,
    output logic                o_if_fault,
    output logic                o_if_done,

    // Load port.
    input  logic                i_ld_req,
    input  axi_lite_pkg::t_addr i_ld_addr,
    output axi_lite_pkg::t_data o_ld_data,
    output logic                o_ld_fault,
    output logic                o_ld_done,

    // Store port.
    input  logic                i_st_req,
    input  axi_lite_pkg::t_addr i_st_addr,
    input  axi_lite_pkg::t_data i_st_data,
    input  axi_lite_pkg::t_strb i_st_strb,
    output logic                o_st_fault,
    output logic                o_st_done
);

    // Arbiter to read master.
    logic                start_read;
    axi_lite_pkg::t_addr rd_addr;
    axi_lite_pkg::t_data rd_data;
    logic                rd_fault;
    logic                rd_done;

    // AXI read channel.
    logic                ar_valid;
    logic                ar_ready;
    axi_lite_pkg::t_addr ar_addr;
    axi_lite_pkg::t_data r_data;
    axi_lite_pkg::t_resp r_resp;
    logic                r_valid;
    logic                r_ready;

    // AXI write channel.
    logic                aw_valid;
    logic                aw_ready;
    axi_lite_pkg::t_addr aw_addr;
    logic                w_valid;
    logic                w_ready;
    axi_lite_pkg::t_data w_data;
    axi_lite_pkg::t_strb w_strb;
    logic                b_valid;
    logic                b_ready;
    axi_lite_pkg::t_resp b_resp;

    mem_arbiter u_arbiter (
        .clk          (clk),
        .arstn        (arstn),
        .i_if_req     (i_if_req),
        .i_if_addr    (i_if_addr),
        .o_if_data    (o_if_data),
        .o_if_fault   (o_if_fault),
        .o_if_done    (o_if_done),
        .i_ld_req     (i_ld_req),
        .i_ld_addr    (i_ld_addr),
        .o_ld_data    (o_ld_data),
        .o_ld_fault   (o_ld_fault),
        .o_ld_done    (o_ld_done),
        .o_start_read (start_read),
        .o_addr       (rd_addr),
        .i_rd_data    (rd_data),
        .i_rd_fault   (rd_fault),
        .i_rd_done    (rd_done)
    );

    axi4_lite_master_read u_master_read (
        .clk            (clk),
        .arstn          (arstn),
        .i_addr         (rd_addr),
        .i_start_read   (start_read),
        .o_data         (rd_data),
        .o_access_fault (rd_fault),
        .o_done         (rd_done),
        .AR_READY       (ar_ready),
        .AR_VALID       (ar_valid),
        .AR_ADDR        (ar_addr),
        .R_DATA         (r_data),
        .R_RESP         (r_resp),
        .R_VALID        (r_valid),
        .R_READY        (r_ready)
    );

    // Stores bypass the arbiter.
    axi4_lite_master_write u_master_write (
        .clk            (clk),
        .arstn          (arstn),
        .i_addr         (i_st_addr),
        .i_data         (i_st_data),
        .i_strb         (i_st_strb),
        .i_start_write  (i_st_req),
        .o_access_fault (o_st_fault),
        .o_done         (o_st_done),
        .AW_READY       (aw_ready),
        .AW_VALID       (aw_valid),
        .AW_ADDR        (aw_addr),
        .W_READY        (w_ready),
        .W_VALID        (w_valid),
        .W_DATA         (w_data),
        .W_STRB         (w_strb),
        .B_VALID        (b_valid),
        .B_RESP         (b_resp),
        .B_READY        (b_ready)
    );

    axi4_lite_memory u_memory (
        .clk      (clk),
        .arstn    (arstn),
        .AR_VALID (ar_valid),
        .AR_ADDR  (ar_addr),
        .AR_READY (ar_ready),
        .R_DATA   (r_data),
        .R_RESP   (r_resp),
        .R_VALID  (r_valid),
        .R_READY  (r_ready),
        .AW_VALID (aw_valid),
        .AW_ADDR  (aw_addr),
        .AW_READY (aw_ready),
        .W_VALID  (w_valid),
        .W_DATA   (w_data),
        .W_STRB   (w_strb),
        .W_READY  (w_ready),
        .B_VALID  (b_valid),
        .B_RESP   (b_resp),
        .B_READY  (b_ready)
    );

endmodule

`default_nettype wire

// File: tests/tb_mem_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "axi_lite_defs.svh"

module tb_mem_subsystem;

    localparam int CLK_PERIOD = 20;
    localparam int WORDS      = 1 << `MEM_WORDS_LOG2;
    localparam int LANES      = `AXI_DATA_WIDTH / 8;

    // Transactions per test section.
    localparam int N_FULL     = 20;
    localparam int N_STRB     = 20;
    localparam int N_OOR      = 10;
    localparam int N_OOR_ST   = 6;
    localparam int N_CONTEST  = 8;
    localparam int TOTAL_TXN  = WORDS + 2 * N_FULL + 3 * N_STRB + 2 * N_OOR
                                + 2 * N_OOR_ST + 3 * N_CONTEST;
    // 40 cycles per transaction plus reset and slack.
    localparam int WATCHDOG_CYCLES = TOTAL_TXN * 40 + 200;

    logic                clk;
    logic                arstn;
    logic                i_if_req;
    axi_lite_pkg::t_addr i_if_addr;
    axi_lite_pkg::t_data o_if_data;
    logic                o_if_fault;
    logic                o_if_done;
    logic                i_ld_req;
    axi_lite_pkg::t_addr i_ld_addr;
    axi_lite_pkg::t_data o_ld_data;
    logic                o_ld_fault;
    logic                o_ld_done;
    logic                i_st_req;
    axi_lite_pkg::t_addr i_st_addr;
    axi_lite_pkg::t_data i_st_data;
    axi_lite_pkg::t_strb i_st_strb;
    logic                o_st_fault;
    logic                o_st_done;

    mem_subsystem_top UUT (
        .clk        (clk),
        .arstn      (arstn),
        .i_if_req   (i_if_req),
        .i_if_addr  (i_if_addr),
        .o_if_data  (o_if_data),
        .o_if_fault (o_if_fault),
        .o_if_done  (o_if_done),
        .i_ld_req   (i_ld_req),
        .i_ld_addr  (i_ld_addr),
        .o_ld_data  (o_ld_data),
        .o_ld_fault (o_ld_fault),
        .o_ld_done  (o_ld_done),
        .i_st_req   (i_st_req),
        .i_st_addr  (i_st_addr),
        .i_st_data  (i_st_data),
        .i_st_strb  (i_st_strb),
        .o_st_fault (o_st_fault),
        .o_st_done  (o_st_done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------------------------
    // Reference model.
    // ----------------------------------------------------------

    axi_lite_pkg::t_data ref_mem [WORDS];

    // Expected results in issue order.
    axi_lite_pkg::t_data exp_if_data [$];
    logic                exp_if_fault [$];
    axi_lite_pkg::t_data exp_ld_data [$];
    logic                exp_ld_fault [$];
    logic                exp_st_fault [$];

    // Done order with 0 for fetch and 1 for load.
    int   done_order [$];
    int   if_done_cnt = 0;
    int   ld_done_cnt = 0;
    int   st_done_cnt = 0;
    // Set when the load port was served last.
    logic last_ld;

    logic [31:0] lcg_state = 32'h44234d71;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Memory spans WORDS * 4 bytes from zero.
    function automatic logic in_range(input axi_lite_pkg::t_addr addr);
        return addr < axi_lite_pkg::t_addr'(WORDS * 4);
    endfunction

    function automatic axi_lite_pkg::t_data ref_read(input axi_lite_pkg::t_addr addr);
        return in_range(addr) ? ref_mem[addr / 4] : '0;
    endfunction

    function automatic logic ref_fault(input axi_lite_pkg::t_addr addr);
        return !in_range(addr);
    endfunction

    function automatic void ref_write(input axi_lite_pkg::t_addr addr,
                                      input axi_lite_pkg::t_data data,
                                      input axi_lite_pkg::t_strb strb);
        if (in_range(addr)) begin
            for (int b = 0; b < LANES; b++) begin
                if (strb[b]) ref_mem[addr / 4][8 * b +: 8] = data[8 * b +: 8];
            end
        end
    endfunction

    // Initial contents hashed from the word index.
    function automatic axi_lite_pkg::t_data fill_word(input int idx);
        return axi_lite_pkg::t_data'((idx + 1) * 32'h9e3779b9);
    endfunction

    // Word aligned address inside the array.
    function automatic axi_lite_pkg::t_addr rand_addr();
        return axi_lite_pkg::t_addr'(next_random() % WORDS) * 4;
    endfunction

    // One random bit above the array set.
    function automatic axi_lite_pkg::t_addr rand_far_addr();
        axi_lite_pkg::t_addr base;
        int unsigned         pos;
        base = rand_addr();
        pos  = `MEM_WORDS_LOG2 + 2
               + next_random() % (`AXI_ADDR_WIDTH - `MEM_WORDS_LOG2 - 2);
        return base | (axi_lite_pkg::t_addr'(1) << pos);
    endfunction

    // ----------------------------------------------------------
    // Checks.
    // ----------------------------------------------------------

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_data(input string what, input axi_lite_pkg::t_data got,
                              input axi_lite_pkg::t_data exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t: %s data is %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_fault(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Error at %0t: %s fault is %b, expected %b",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_order(input int got, input int exp);
        if (got != exp) begin
            fail_run($sformatf("Error at %0t: port %0d finished first, expected port %0d",
                               $time, got, exp));
        end
    endtask

    // Compare at the falling edge where outputs are settled.
    always @(negedge clk) begin
        if (o_if_done) begin
            if (exp_if_data.size() == 0) fail_run("Fetch port finished a read it never got");
            check_data("fetch", o_if_data, exp_if_data.pop_front());
            check_fault("fetch", o_if_fault, exp_if_fault.pop_front());
            done_order.push_back(0);
            if_done_cnt++;
        end
        if (o_ld_done) begin
            if (exp_ld_data.size() == 0) fail_run("Load port finished a read it never got");
            check_data("load", o_ld_data, exp_ld_data.pop_front());
            check_fault("load", o_ld_fault, exp_ld_fault.pop_front());
            done_order.push_back(1);
            ld_done_cnt++;
        end
        if (o_st_done) begin
            if (exp_st_fault.size() == 0) fail_run("Store port finished a store it never got");
            check_fault("store", o_st_fault, exp_st_fault.pop_front());
            st_done_cnt++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run($sformatf("Watchdog expired after %0d cycles, the DUT stopped responding",
                           WATCHDOG_CYCLES));
    end

    // ----------------------------------------------------------
    // Stimulus tasks.
    // ----------------------------------------------------------

    task automatic apply_reset();
        @(posedge clk);
        #1;
        arstn = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        if (o_if_done || o_ld_done || o_st_done) fail_run("A done output is high in reset");
        arstn   = 1'b1;
        // Arbiter favors the fetch port after reset.
        last_ld = 1'b1;
    endtask

    task automatic issue_store(input axi_lite_pkg::t_addr addr,
                               input axi_lite_pkg::t_data data,
                               input axi_lite_pkg::t_strb strb);
        int target;
        target = st_done_cnt + 1;
        @(posedge clk);
        #1;
        i_st_req  = 1'b1;
        i_st_addr = addr;
        i_st_data = data;
        i_st_strb = strb;
        exp_st_fault.push_back(ref_fault(addr));
        ref_write(addr, data, strb);
        @(posedge clk);
        #1;
        i_st_req = 1'b0;
        wait (st_done_cnt == target);
    endtask

    // One read on either port or on both in the same cycle.
    task automatic issue_reads(input logic do_if, input logic do_ld,
                               input axi_lite_pkg::t_addr if_addr,
                               input axi_lite_pkg::t_addr ld_addr);
        int if_target;
        int ld_target;
        int first;
        if_target = if_done_cnt + do_if;
        ld_target = ld_done_cnt + do_ld;
        done_order.delete();
        @(posedge clk);
        #1;
        if (do_if) begin
            i_if_req  = 1'b1;
            i_if_addr = if_addr;
            exp_if_data.push_back(ref_read(if_addr));
            exp_if_fault.push_back(ref_fault(if_addr));
        end
        if (do_ld) begin
            i_ld_req  = 1'b1;
            i_ld_addr = ld_addr;
            exp_ld_data.push_back(ref_read(ld_addr));
            exp_ld_fault.push_back(ref_fault(ld_addr));
        end
        @(posedge clk);
        #1;
        i_if_req = 1'b0;
        i_ld_req = 1'b0;
        wait (if_done_cnt == if_target && ld_done_cnt == ld_target);
        if (do_if && do_ld) begin
            // Port served less recently wins.
            first = last_ld ? 0 : 1;
            check_order(done_order[0], first);
            last_ld = (first == 0);
        end else begin
            last_ld = do_ld;
        end
    endtask

    // ----------------------------------------------------------
    // Test sequence.
    // ----------------------------------------------------------

    initial begin
        axi_lite_pkg::t_addr addr;
        axi_lite_pkg::t_data data;
        axi_lite_pkg::t_strb strb;
        logic [31:0]         sel;
        arstn     = 1'b0;
        i_if_req  = 1'b0;
        i_if_addr = '0;
        i_ld_req  = 1'b0;
        i_ld_addr = '0;
        i_st_req  = 1'b0;
        i_st_addr = '0;
        i_st_data = '0;
        i_st_strb = '0;
        last_ld   = 1'b1;
        apply_reset();

        // Known contents everywhere.
        for (int i = 0; i < WORDS; i++) issue_store(i * 4, fill_word(i), '1);

        // Full word store followed by a load.
        for (int n = 0; n < N_FULL; n++) begin
            addr = rand_addr();
            data = next_random();
            issue_store(addr, data, '1);
            issue_reads(1'b0, 1'b1, '0, addr);
        end

        // Partial stores read back on both ports.
        for (int n = 0; n < N_STRB; n++) begin
            addr = rand_addr();
            data = next_random();
            strb = axi_lite_pkg::t_strb'(next_random());
            issue_store(addr, data, strb);
            issue_reads(1'b1, 1'b0, addr, '0);
            issue_reads(1'b0, 1'b1, '0, addr);
        end

        // Reads past the array.
        for (int n = 0; n < N_OOR; n++) begin
            issue_reads(1'b1, 1'b0, rand_far_addr(), '0);
            issue_reads(1'b0, 1'b1, '0, rand_far_addr());
        end

        // Store past the array and read the aliased low word.
        for (int n = 0; n < N_OOR_ST; n++) begin
            addr = rand_far_addr();
            issue_store(addr, next_random(), '1);
            issue_reads(1'b0, 1'b1, '0, addr & axi_lite_pkg::t_addr'(WORDS * 4 - 1));
        end

        // Contests with the first right after reset.
        apply_reset();
        for (int n = 0; n < N_CONTEST; n++) begin
            issue_reads(1'b1, 1'b1, rand_addr(), rand_addr());
            sel = next_random();
            issue_reads(sel[0], ~sel[0], rand_addr(), rand_addr());
        end

        repeat (2) @(posedge clk);
        if (exp_if_data.size() == 0 && exp_ld_data.size() == 0
                && exp_st_fault.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            fail_run("Run ended with transactions still outstanding");
        end
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/axi_lite_pkg.sv
axi_master/axi4_lite_master_read.sv
axi_master/axi4_lite_master_write.sv
logic/mem_arbiter.sv
logic/axi4_lite_memory.sv
logic/mem_subsystem_top.sv
tests/tb_mem_subsystem.sv
